// ==== list.f ====
+incdir+source
source/rv_isa_pkg.sv
source/core_pkg.sv
source/fetch_decode.sv
source/execute.sv
source/hazard_unit.sv
source/load_store_unit.sv
source/pineapple_core.sv
test/core_properties.sv
test/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module core_tb -Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== test/core_tb.sv ====
`include "core_defines.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
    logic             instr_valid = 1'b0;
    logic             data_req, data_we;
    logic [`XLEN-1:0] data_addr, data_wdata;
    logic [3:0]       data_be;
    logic             data_ready = 1'b0;
    logic [`XLEN-1:0] data_rdata = '0;

    logic [31:0]      rom [64];
    logic [31:0]      ram [256];
    int               rom_len;
    logic             stall_mode = 1'b0;
    logic [31:0]      lfsr = 32'h4776_850e;
    int               errors = 0;
    int               checks = 0;
    logic [`XLEN-1:0] log_addr [$];
    logic [`XLEN-1:0] log_data [$];
    logic [3:0]       log_be [$];

    pineapple_core u_pineapple_core (.*);

    always #5 clk = ~clk;

    assign instr = rom[pc[7:2]];

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return b;
    endfunction

    // Roughly 75% valid and ready under stalls
    always @(posedge clk) begin
        if (stall_mode) begin
            instr_valid <= lfsr_bit() | lfsr_bit();
            data_ready  <= lfsr_bit() | lfsr_bit();
        end else begin
            instr_valid <= 1'b1;
            data_ready  <= 1'b1;
        end
    end

    // Data RAM returns read data the cycle after acceptance
    always @(posedge clk) begin
        if (!reset && data_req && data_ready) begin
            if (data_we) begin
                for (int k = 0; k < 4; k++)
                    if (data_be[k])
                        ram[data_addr[9:2]][8*k +: 8] = data_wdata[8*k +: 8];
                log_addr.push_back(data_addr);
                log_data.push_back(data_wdata);
                log_be.push_back(data_be);
            end else begin
                data_rdata <= ram[data_addr[9:2]];
            end
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] sext8(logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[rom_len] = w;
        rom_len++;
    endtask

    task automatic begin_test(input logic stalls);
        @(posedge clk);
        reset      <= 1'b1;
        stall_mode <= stalls;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 64; i++)
            rom[i] = NOP;
        rom_len = 0;
        log_addr.delete();
        log_data.delete();
        log_be.delete();
    endtask

    task automatic run_program(input int n, input string name);
        int cycles;
        cycles = 0;
        // Park the core in a jump to itself
        emit(j_type(21'd0, 5'd0));
        @(posedge clk);
        reset <= 1'b0;
        while (log_addr.size() < n && cycles < 150) begin
            @(negedge clk);
            cycles++;
        end
        if (log_addr.size() < n) begin
            $display("Timeout in test %s: saw %0d of %0d stores", name, log_addr.size(), n);
            errors++;
        end
        repeat (16) @(negedge clk);
    endtask

    task automatic check_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                               input logic [3:0] be);
        checks++;
        if (log_addr.size() == 0) begin
            $display("ERROR %0t: missing store to %h", $time, addr);
            errors++;
        end else if (log_addr[0] != addr || log_data[0] != data || log_be[0] != be) begin
            $display("ERROR %0t: store got %h/%h/%h expected %h/%h/%h", $time,
                     log_addr[0], log_data[0], log_be[0], addr, data, be);
            errors++;
        end
        if (log_addr.size() != 0) begin
            void'(log_addr.pop_front());
            void'(log_data.pop_front());
            void'(log_be.pop_front());
        end
    endtask

    task automatic check_pc(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] exp_pc);
        checks++;
        if (log_addr.size() == 0) begin
            $display("ERROR %0t: missing link store to %h", $time, addr);
            errors++;
        end else begin
            if (log_addr[0] != addr || log_data[0] != exp_pc) begin
                $display("ERROR %0t: link at %h is %h, expected %h at %h", $time,
                         log_addr[0], log_data[0], exp_pc, addr);
                errors++;
            end
            void'(log_addr.pop_front());
            void'(log_data.pop_front());
            void'(log_be.pop_front());
        end
    endtask

    task automatic end_test(input string name);
        if (log_addr.size() != 0) begin
            $display("Test %s made %0d unexpected stores, first to address %h",
                     name, log_addr.size(), log_addr[0]);
            errors++;
        end
    endtask

    task automatic test_alu_chain(input logic stalls);
        logic [31:0] v [17];
        int          st [13] = '{3, 4, 5, 6, 7, 8, 10, 11, 12, 13, 14, 15, 16};
        begin_test(stalls);
        emit(i_type(12'h123, 0, 3'b000, 1, OP_IMM));
        emit(i_type(12'hffb, 1, 3'b000, 2, OP_IMM));
        emit(r_type(7'h00, 2, 1, 3'b000, 3));
        emit(r_type(7'h20, 1, 3, 3'b000, 4));
        emit(r_type(7'h00, 3, 4, 3'b111, 5));
        emit(r_type(7'h00, 1, 5, 3'b110, 6));
        emit(r_type(7'h00, 2, 6, 3'b100, 7));
        emit(r_type(7'h00, 7, 2, 3'b010, 8));
        emit(i_type(12'd3, 0, 3'b000, 9, OP_IMM));
        emit(r_type(7'h00, 9, 7, 3'b001, 10));
        emit(r_type(7'h00, 9, 10, 3'b101, 11));
        emit({20'habcde, 5'd12, OP_LUI});
        emit(r_type(7'h00, 11, 12, 3'b000, 13));
        emit(i_type(12'h0f0, 13, 3'b110, 14, OP_IMM));
        emit(i_type(12'h3ff, 14, 3'b111, 15, OP_IMM));
        emit(i_type(12'h100, 15, 3'b010, 16, OP_IMM));
        for (int k = 0; k < 13; k++)
            emit(s_type(12'h100 + 12'(4 * k), 5'(st[k]), 0, 3'b010));
        v[1]  = 32'h123;
        v[2]  = v[1] - 32'd5;
        v[3]  = v[1] + v[2];
        v[4]  = v[3] - v[1];
        v[5]  = v[4] & v[3];
        v[6]  = v[5] | v[1];
        v[7]  = v[6] ^ v[2];
        v[8]  = ($signed(v[2]) < $signed(v[7])) ? 32'd1 : 32'd0;
        v[10] = v[7] << 3;
        v[11] = v[10] >> 3;
        v[12] = 32'habcd_e000;
        v[13] = v[12] + v[11];
        v[14] = v[13] | 32'h0f0;
        v[15] = v[14] & 32'h3ff;
        v[16] = ($signed(v[15]) < 32'sd256) ? 32'd1 : 32'd0;
        run_program(13, "alu chain");
        for (int k = 0; k < 13; k++)
            check_store(32'h100 + 32'(4 * k), v[st[k]], 4'hf);
        end_test("alu chain");
    endtask

    task automatic test_loads(input logic stalls);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = 32'h8000_00f5;
        w1 = 32'h1234_5687;
        begin_test(stalls);
        ram[128] = w0;
        ram[129] = w1;
        emit(i_type(12'h200, 0, 3'b000, 1, OP_IMM));
        emit(i_type(12'd100, 0, 3'b000, 2, OP_IMM));
        emit(i_type(12'd0, 1, 3'b010, 3, OP_LOAD));
        emit(r_type(7'h00, 2, 3, 3'b000, 4));
        emit(i_type(12'd4, 1, 3'b000, 5, OP_LOAD));
        emit(r_type(7'h00, 2, 5, 3'b000, 6));
        emit(i_type(12'd4, 1, 3'b100, 7, OP_LOAD));
        emit(r_type(7'h00, 2, 7, 3'b000, 8));
        emit(i_type(12'd3, 1, 3'b000, 9, OP_LOAD));
        emit(r_type(7'h00, 9, 9, 3'b000, 10));
        emit(s_type(12'h300, 4, 0, 3'b010));
        emit(s_type(12'h304, 6, 0, 3'b010));
        emit(s_type(12'h308, 8, 0, 3'b010));
        emit(s_type(12'h30c, 10, 0, 3'b010));
        run_program(4, "loads");
        check_store(32'h300, w0 + 32'd100, 4'hf);
        check_store(32'h304, sext8(w1[7:0]) + 32'd100, 4'hf);
        check_store(32'h308, {24'd0, w1[7:0]} + 32'd100, 4'hf);
        check_store(32'h30c, sext8(w0[31:24]) + sext8(w0[31:24]), 4'hf);
        end_test("loads");
    endtask

    task automatic test_byte_stores();
        begin_test(1'b0);
        emit(i_type(12'h1a5, 0, 3'b000, 1, OP_IMM));
        for (int k = 0; k < 4; k++)
            emit(s_type(12'h400 + 12'(k), 1, 0, 3'b000));
        emit(s_type(12'h404, 1, 0, 3'b010));
        run_program(5, "byte stores");
        for (int k = 0; k < 4; k++)
            check_store(32'h400 + 32'(k), {4{8'ha5}}, 4'b0001 << k);
        check_store(32'h404, 32'h1a5, 4'hf);
        end_test("byte stores");
    endtask

    task automatic test_control();
        begin_test(1'b0);
        emit(i_type(12'd7, 0, 3'b000, 1, OP_IMM));
        emit(i_type(12'd7, 0, 3'b000, 2, OP_IMM));
        emit(b_type(13'd8, 2, 1, 3'b000));
        // Skipped by the taken BEQ
        emit(s_type(12'h500, 1, 0, 3'b010));
        emit(b_type(13'd8, 2, 1, 3'b001));
        emit(s_type(12'h504, 1, 0, 3'b010));
        emit(i_type(12'd1, 0, 3'b000, 3, OP_IMM));
        emit(b_type(13'd8, 3, 1, 3'b001));
        emit(s_type(12'h508, 3, 0, 3'b010));
        emit(b_type(13'd8, 3, 1, 3'b000));
        emit(s_type(12'h50c, 3, 0, 3'b010));
        emit(j_type(21'd8, 5));
        emit(s_type(12'h510, 1, 0, 3'b010));
        emit(s_type(12'h514, 5, 0, 3'b010));
        run_program(3, "control flow");
        check_store(32'h504, 32'd7, 4'hf);
        check_store(32'h50c, 32'd1, 4'hf);
        // JAL sits at word 11
        check_pc(32'h514, 32'd11 * 4 + 4);
        end_test("control flow");
    endtask

    initial begin
        for (int i = 0; i < 256; i++)
            ram[i] = 32'h9e37_79b9 * (i + 1);
        for (int i = 0; i < 64; i++)
            rom[i] = NOP;
        test_alu_chain(1'b0);
        test_loads(1'b0);
        test_byte_stores();
        test_control();
        test_alu_chain(1'b1);
        test_loads(1'b1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("Watchdog expired before the tests finished");
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== test/core_properties.sv ====
`include "core_defines.svh"

module core_properties (
    input logic             clk,
    input logic             reset,
    input logic [`XLEN-1:0] pc,
    input logic             instr_valid,
    input logic             data_req,
    input logic             data_we,
    input logic [`XLEN-1:0] data_addr,
    input logic [`XLEN-1:0] data_wdata,
    input logic [3:0]       data_be,
    input logic             data_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    a_req_after_reset: assert property (@(posedge clk) reset |=> !data_req)
        else $error("data_req high after reset");

    // Request held until accepted
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_ready |=> data_req && $stable(data_addr) &&
                                    $stable(data_wdata) && $stable(data_be))
        else $error("data request changed before acceptance");

    a_be_nonzero: assert property (@(posedge clk) disable iff (reset)
        data_req && data_we |-> data_be != 4'b0000)
        else $error("write with empty byte enable");

    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        !instr_valid |=> $stable(pc))
        else $error("pc moved while instr_valid low");

endmodule

bind pineapple_core core_properties u_core_properties (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .instr_valid (instr_valid),
    .data_req    (data_req),
    .data_we     (data_we),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_be     (data_be),
    .data_ready  (data_ready)
);

// ==== source/pineapple_core.sv ====
`include "core_defines.svh"

module pineapple_core (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] instr,
    input  logic             instr_valid,
    output logic             data_req,
    output logic             data_we,
    output logic [`XLEN-1:0] data_addr,
    output logic [`XLEN-1:0] data_wdata,
    output logic [3:0]       data_be,
    input  logic             data_ready,
    input  logic [`XLEN-1:0] data_rdata
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [`XLEN-1:0] regs [`NUM_REGS];

    logic [`XLEN-1:0] dec_imm;
    alu_op_t          dec_alu_op;
    src_a_t           dec_src_a;
    src_b_t           dec_src_b;
    logic             dec_mem_w, dec_reg_w, dec_mem2reg, dec_bra, dec_jmp;
    logic             dec_use_rs1, dec_use_rs2;

    // Execute stage
    logic             exec_mem_w, exec_reg_w, exec_mem2reg, exec_bra, exec_jmp;
    logic [`XLEN-1:0] exec_pc, exec_imm, exec_rs1_val, exec_rs2_val;
    logic [4:0]       exec_rs1, exec_rs2, exec_rd;
    logic [2:0]       exec_funct3;
    alu_op_t          exec_alu_op;
    src_a_t           exec_src_a;
    src_b_t           exec_src_b;

    // Memory and writeback stages
    logic             mem_mem_w, mem_reg_w, mem_mem2reg;
    logic [`XLEN-1:0] mem_alu, mem_store_data;
    logic [4:0]       mem_rd;
    mem_size_t        mem_size;
    logic             wb_reg_w, wb_mem2reg;
    logic [`XLEN-1:0] wb_alu;
    logic [4:0]       wb_rd;
    mem_size_t        wb_size;

    logic [`XLEN-1:0] ex_alu_out, ex_store_data, ex_target;
    logic             ex_cmp;
    fwd_sel_t         fwd_rs1, fwd_rs2;
    logic             fetch_stall, pipe_stall, exec_flush, mem_flush;
    logic             redirect, exec_hold;
    logic [4:0]       rd1_addr, rd2_addr;
    logic [`XLEN-1:0] rd1_val, rd2_val;
    logic [`XLEN-1:0] load_data, wb_result;

    fetch_decode u_fetch_decode (
        .instr   (instr),
        .imm     (dec_imm),
        .alu_op  (dec_alu_op),
        .src_a   (dec_src_a),
        .src_b   (dec_src_b),
        .mem_w   (dec_mem_w),
        .reg_w   (dec_reg_w),
        .mem2reg (dec_mem2reg),
        .bra     (dec_bra),
        .jmp     (dec_jmp),
        .use_rs1 (dec_use_rs1),
        .use_rs2 (dec_use_rs2)
    );

    execute u_execute (
        .alu_op     (exec_alu_op),
        .src_a      (exec_src_a),
        .src_b      (exec_src_b),
        .fwd_rs1    (fwd_rs1),
        .fwd_rs2    (fwd_rs2),
        .rs1_val    (exec_rs1_val),
        .rs2_val    (exec_rs2_val),
        .mem_result (mem_alu),
        .wb_result  (wb_result),
        .pc_in      (exec_pc),
        .imm        (exec_imm),
        .bra_ne     (branch_t'(exec_funct3[0])),
        .alu_out    (ex_alu_out),
        .store_data (ex_store_data),
        .target     (ex_target),
        .cmp_eq     (ex_cmp)
    );

    hazard_unit u_hazard_unit (
        .exec_rs1     (exec_rs1),
        .exec_rs2     (exec_rs2),
        .mem_rd       (mem_rd),
        .wb_rd        (wb_rd),
        .fetch_rs1    (`RS1(instr)),
        .fetch_rs2    (`RS2(instr)),
        .exec_rd      (exec_rd),
        .mem_reg_w    (mem_reg_w),
        .wb_reg_w     (wb_reg_w),
        .exec_mem2reg (exec_mem2reg),
        .use_rs1      (dec_use_rs1),
        .use_rs2      (dec_use_rs2),
        .redirect     (redirect),
        .instr_valid  (instr_valid),
        .data_req     (data_req),
        .data_ready   (data_ready),
        .fwd_rs1      (fwd_rs1),
        .fwd_rs2      (fwd_rs2),
        .fetch_stall  (fetch_stall),
        .pipe_stall   (pipe_stall),
        .exec_flush   (exec_flush),
        .mem_flush    (mem_flush)
    );

    load_store_unit u_load_store_unit (
        .mem_size     (mem_size),
        .wb_size      (wb_size),
        .mem_addr_low (mem_alu[1:0]),
        .wb_addr_low  (wb_alu[1:0]),
        .store_data   (mem_store_data),
        .rdata        (data_rdata),
        .wdata        (data_wdata),
        .be           (data_be),
        .load_data    (load_data)
    );

    // Branches predicted not taken
    assign redirect  = (exec_bra && ex_cmp) || exec_jmp;
    assign exec_hold = pipe_stall || mem_flush;

    assign data_req  = mem_mem_w || mem_mem2reg;
    assign data_we   = mem_mem_w;
    assign data_addr = mem_alu;
    assign wb_result = wb_mem2reg ? load_data : wb_alu;

    // A held instruction rereads its sources so retired results are not lost
    assign rd1_addr = exec_hold ? exec_rs1 : `RS1(instr);
    assign rd2_addr = exec_hold ? exec_rs2 : `RS2(instr);
    assign rd1_val  = (rd1_addr == 5'd0) ? '0 :
                      (wb_reg_w && wb_rd == rd1_addr) ? wb_result : regs[rd1_addr];
    assign rd2_val  = (rd2_addr == 5'd0) ? '0 :
                      (wb_reg_w && wb_rd == rd2_addr) ? wb_result : regs[rd2_addr];

    always_ff @(posedge clk) begin
        if (wb_reg_w)
            regs[wb_rd] <= wb_result;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RESET_PC;
        else if (!fetch_stall)
            pc <= redirect ? ex_target : pc + `XLEN'(4);
    end

    always_ff @(posedge clk) begin
        if (reset || (exec_flush && !exec_hold)) begin
            exec_mem_w   <= 1'b0;
            exec_reg_w   <= 1'b0;
            exec_mem2reg <= 1'b0;
            exec_bra     <= 1'b0;
            exec_jmp     <= 1'b0;
        end else if (!exec_hold) begin
            exec_mem_w   <= dec_mem_w;
            exec_reg_w   <= dec_reg_w;
            exec_mem2reg <= dec_mem2reg;
            exec_bra     <= dec_bra;
            exec_jmp     <= dec_jmp;
        end
    end

    always_ff @(posedge clk) begin
        exec_rs1_val <= rd1_val;
        exec_rs2_val <= rd2_val;
        if (!exec_hold) begin
            exec_pc     <= pc;
            exec_imm    <= dec_imm;
            exec_rs1    <= `RS1(instr);
            exec_rs2    <= `RS2(instr);
            exec_rd     <= `RD(instr);
            exec_funct3 <= `FUNCT3(instr);
            exec_alu_op <= dec_alu_op;
            exec_src_a  <= dec_src_a;
            exec_src_b  <= dec_src_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || mem_flush) begin
            mem_mem_w   <= 1'b0;
            mem_reg_w   <= 1'b0;
            mem_mem2reg <= 1'b0;
        end else if (!pipe_stall) begin
            mem_mem_w   <= exec_mem_w;
            mem_reg_w   <= exec_reg_w;
            mem_mem2reg <= exec_mem2reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            mem_alu        <= ex_alu_out;
            mem_store_data <= ex_store_data;
            mem_rd         <= exec_rd;
            mem_size       <= mem_size_t'(exec_funct3);
        end
    end

    // Writeback drains during a data stall, load data is only valid once
    always_ff @(posedge clk) begin
        if (reset || pipe_stall) begin
            wb_reg_w   <= 1'b0;
            wb_mem2reg <= 1'b0;
        end else begin
            wb_reg_w   <= mem_reg_w;
            wb_mem2reg <= mem_mem2reg;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu  <= mem_alu;
        wb_rd   <= mem_rd;
        wb_size <= mem_size;
    end

endmodule

// ==== source/load_store_unit.sv ====
`include "core_defines.svh"

module load_store_unit (
    input  rv_isa_pkg::mem_size_t mem_size,
    input  rv_isa_pkg::mem_size_t wb_size,
    input  logic [1:0]            mem_addr_low,
    input  logic [1:0]            wb_addr_low,
    input  logic [`XLEN-1:0]      store_data,
    input  logic [`XLEN-1:0]      rdata,
    output logic [`XLEN-1:0]      wdata,
    output logic [3:0]            be,
    output logic [`XLEN-1:0]      load_data
);
    import rv_isa_pkg::*;

    logic [7:0] ld_byte;

    // Byte store goes out on every lane, enable picks the one
    always_comb begin
        if (mem_size == MEM_WORD) begin
            wdata = store_data;
            be    = 4'b1111;
        end else begin
            wdata = {4{store_data[7:0]}};
            be    = 4'b0001 << mem_addr_low;
        end
    end

    assign ld_byte = rdata[{wb_addr_low, 3'b000} +: 8];

    always_comb begin
        case (wb_size)
            MEM_WORD:   load_data = rdata;
            MEM_BYTE_U: load_data = {{(`XLEN-8){1'b0}}, ld_byte};
            default:    load_data = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
        endcase
    end

endmodule

// ==== source/hazard_unit.sv ====
module hazard_unit (
    input  logic [4:0]         exec_rs1,
    input  logic [4:0]         exec_rs2,
    input  logic [4:0]         mem_rd,
    input  logic [4:0]         wb_rd,
    input  logic [4:0]         fetch_rs1,
    input  logic [4:0]         fetch_rs2,
    input  logic [4:0]         exec_rd,
    input  logic               mem_reg_w,
    input  logic               wb_reg_w,
    input  logic               exec_mem2reg,
    input  logic               use_rs1,
    input  logic               use_rs2,
    input  logic               redirect,
    input  logic               instr_valid,
    input  logic               data_req,
    input  logic               data_ready,
    output core_pkg::fwd_sel_t fwd_rs1,
    output core_pkg::fwd_sel_t fwd_rs2,
    output logic               fetch_stall,
    output logic               pipe_stall,
    output logic               exec_flush,
    output logic               mem_flush
);
    import core_pkg::*;

    logic load_use;

    // Memory stage wins over writeback, x0 is never forwarded
    function automatic fwd_sel_t pick(input logic [4:0] rs,
                                      input logic [4:0] m_rd, input logic m_w,
                                      input logic [4:0] w_rd, input logic w_w);
        if (rs == 5'd0)
            return FWD_REG;
        if (m_w && m_rd == rs)
            return FWD_FROM_MEM;
        if (w_w && w_rd == rs)
            return FWD_FROM_WB;
        return FWD_REG;
    endfunction

    assign fwd_rs1 = pick(exec_rs1, mem_rd, mem_reg_w, wb_rd, wb_reg_w);
    assign fwd_rs2 = pick(exec_rs2, mem_rd, mem_reg_w, wb_rd, wb_reg_w);

    assign load_use = exec_mem2reg && exec_rd != 5'd0 &&
                      ((use_rs1 && fetch_rs1 == exec_rd) || (use_rs2 && fetch_rs2 == exec_rd));

    assign pipe_stall  = data_req && !data_ready;
    assign fetch_stall = pipe_stall || load_use || !instr_valid;
    assign exec_flush  = redirect || load_use || !instr_valid;

    // Redirect waits in execute until fetch can take the new pc
    assign mem_flush = redirect && !instr_valid && !pipe_stall;

endmodule

// ==== source/execute.sv ====
`include "core_defines.svh"

module execute (
    input  rv_isa_pkg::alu_op_t alu_op,
    input  core_pkg::src_a_t    src_a,
    input  core_pkg::src_b_t    src_b,
    input  core_pkg::fwd_sel_t  fwd_rs1,
    input  core_pkg::fwd_sel_t  fwd_rs2,
    input  logic [`XLEN-1:0]    rs1_val,
    input  logic [`XLEN-1:0]    rs2_val,
    input  logic [`XLEN-1:0]    mem_result,
    input  logic [`XLEN-1:0]    wb_result,
    input  logic [`XLEN-1:0]    pc_in,
    input  logic [`XLEN-1:0]    imm,
    input  rv_isa_pkg::branch_t bra_ne,
    output logic [`XLEN-1:0]    alu_out,
    output logic [`XLEN-1:0]    store_data,
    output logic [`XLEN-1:0]    target,
    output logic                cmp_eq
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    function automatic logic [`XLEN-1:0] forward(input fwd_sel_t sel,
                                                 input logic [`XLEN-1:0] reg_val,
                                                 input logic [`XLEN-1:0] mem_val,
                                                 input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_FROM_MEM: return mem_val;
            FWD_FROM_WB:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    assign rs1_fwd    = forward(fwd_rs1, rs1_val, mem_result, wb_result);
    assign rs2_fwd    = forward(fwd_rs2, rs2_val, mem_result, wb_result);
    assign store_data = rs2_fwd;

    assign op_a = (src_a == SRC_A_PC) ? pc_in : rs1_fwd;
    // PC plus 4 for the JAL link
    assign op_b = (src_b == SRC_B_IMM) ? imm :
                  (src_a == SRC_A_PC)  ? `XLEN'(4) : rs2_fwd;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign target = pc_in + imm;

    // Branch condition holds: equal for BEQ, unequal for BNE
    assign cmp_eq = (rs1_fwd == rs2_fwd) ^ (bra_ne == BR_NE);

endmodule

// ==== source/fetch_decode.sv ====
`include "core_defines.svh"

module fetch_decode (
    input  logic [`XLEN-1:0]    instr,
    output logic [`XLEN-1:0]    imm,
    output rv_isa_pkg::alu_op_t alu_op,
    output core_pkg::src_a_t    src_a,
    output core_pkg::src_b_t    src_b,
    output logic                mem_w,
    output logic                reg_w,
    output logic                mem2reg,
    output logic                bra,
    output logic                jmp,
    output logic                use_rs1,
    output logic                use_rs2
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    alu_op_t          f3_op;
    logic             f3_ok;

    assign opcode = `OPCODE(instr);
    assign funct3 = `FUNCT3(instr);
    assign funct7 = `FUNCT7(instr);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU op from funct3, shared by register and immediate forms
    always_comb begin
        f3_ok = 1'b1;
        case (alu_funct3_t'(funct3))
            F3_ADD:  f3_op = (opcode == OP_REG && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:  f3_op = ALU_SLL;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_SRL:  f3_op = ALU_SRL;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        // Anything not matched below stays a no-op
        alu_op  = ALU_ADD;
        src_a   = SRC_A_RS1;
        src_b   = SRC_B_IMM;
        imm     = imm_i;
        mem_w   = 1'b0;
        reg_w   = 1'b0;
        mem2reg = 1'b0;
        bra     = 1'b0;
        jmp     = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode_t'(opcode))
            OP_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = imm_u;
                reg_w  = 1'b1;
            end
            OP_JAL: begin
                // PC with register B source yields the link address
                src_a = SRC_A_PC;
                src_b = SRC_B_RS2;
                imm   = imm_j;
                reg_w = 1'b1;
                jmp   = 1'b1;
            end
            OP_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin
                    src_b   = SRC_B_RS2;
                    imm     = imm_b;
                    bra     = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            OP_LOAD: begin
                if (mem_size_t'(funct3) inside {MEM_BYTE, MEM_WORD, MEM_BYTE_U}) begin
                    reg_w   = 1'b1;
                    mem2reg = 1'b1;
                    use_rs1 = 1'b1;
                end
            end
            OP_STORE: begin
                if (mem_size_t'(funct3) inside {MEM_BYTE, MEM_WORD}) begin
                    imm     = imm_s;
                    mem_w   = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            OP_IMM: begin
                // No immediate shifts in this subset
                if (f3_ok && f3_op != ALU_SLL && f3_op != ALU_SRL) begin
                    alu_op  = f3_op;
                    reg_w   = 1'b1;
                    use_rs1 = 1'b1;
                end
            end
            OP_REG: begin
                if (f3_ok && (funct7 == 7'b0 || f3_op == ALU_SUB)) begin
                    alu_op  = f3_op;
                    src_b   = SRC_B_RS2;
                    reg_w   = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_t;

    typedef enum logic {
        SRC_A_RS1,
        SRC_A_PC
    } src_a_t;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_t;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // funct3 of integer ALU instructions
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } alu_funct3_t;

    // funct7 selecting SUB over ADD
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    // Load and store funct3
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100
    } mem_size_t;

    // funct3[0] of BEQ and BNE
    typedef enum logic {
        BR_EQ = 1'b0,
        BR_NE = 1'b1
    } branch_t;

endpackage

// ==== source/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath width
`define XLEN 32

// PC after reset
`define RESET_PC 32'h0000_0000

`define NUM_REGS 32

// Instruction fields, argument must be a plain signal name
`define OPCODE(i) i[6:0]
`define RD(i)     i[11:7]
`define FUNCT3(i) i[14:12]
`define RS1(i)    i[19:15]
`define RS2(i)    i[24:20]
`define FUNCT7(i) i[31:25]

`endif
